// File: verilog/uart_frame_pkg.sv
/*
 * uart text-frame link shared definitions
 * bit timing, frame sizes, the frame struct and the FSM state encodings
 * used by the byte engines and the frame engines
 */
`default_nettype none

package uart_frame_pkg;

	// at least 4 sys_clk cycles per uart bit
	localparam int clks_per_bit = 16;
	localparam int tx_stop_bits = 2;
	localparam int max_bytes    = 32;

	// two '&' bytes mark each end of a frame
	localparam logic [7:0] frame_marker = 8'h26;

	// byte k of text sits at bits 8k+7 down to 8k
	typedef struct packed {
		logic [max_bytes*8-1:0] text;
		logic [7:0]             length;
	} frame_t;

	typedef enum logic [2:0] {
		tx_idle,
		tx_mark1,
		tx_mark2,
		tx_content,
		tx_mark3,
		tx_mark4,
		tx_finish
	} tx_state_e;

	typedef enum logic [1:0] {
		rx_hunt,
		rx_mark1,
		rx_content,
		rx_close
	} rx_state_e;

	typedef enum logic [1:0] {
		line_idle,
		line_start,
		line_data,
		line_stop
	} line_state_e;

endpackage

`default_nettype wire

// File: verilog/uart_byte_tx.sv
/*
 * uart byte transmitter
 * start bit, 8 data bits lsb first, then the configured stop bits
 */
`timescale 1ns/1ps
`default_nettype none

module uart_byte_tx import uart_frame_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_req,
	output logic       byte_done,
	output logic       uart_tx
);

	line_state_e state;
	logic [15:0] clk_cnt;
	logic [3:0]  bit_cnt;
	logic [7:0]  shift_q;
	logic        bit_end;

	assign bit_end   = (clk_cnt == clks_per_bit - 1);
	// last cycle of the final stop bit
	assign byte_done = (state == line_stop) && bit_end && (bit_cnt == tx_stop_bits - 1);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= line_idle;
			clk_cnt <= '0;
			bit_cnt <= '0;
			shift_q <= '0;
			uart_tx <= 1'b1;
		end else if (state == line_idle) begin
			uart_tx <= 1'b1;
			clk_cnt <= '0;
			bit_cnt <= '0;
			if (byte_req) begin
				shift_q <= byte_data;
				uart_tx <= 1'b0;
				state   <= line_start;
			end
		end else if (!bit_end) begin
			clk_cnt <= clk_cnt + 16'd1;
		end else begin
			clk_cnt <= '0;
			case (state)
				line_start: begin
					state   <= line_data;
					bit_cnt <= '0;
					uart_tx <= shift_q[0];
					shift_q <= {1'b0, shift_q[7:1]};
				end
				line_data: begin
					if (bit_cnt == 4'd7) begin
						state   <= line_stop;
						bit_cnt <= '0;
						uart_tx <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 4'd1;
						uart_tx <= shift_q[0];
						shift_q <= {1'b0, shift_q[7:1]};
					end
				end
				line_stop: begin
					if (bit_cnt == tx_stop_bits - 1) begin
						state <= line_idle;
					end else begin
						bit_cnt <= bit_cnt + 4'd1;
					end
				end
				default: state <= line_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_byte_rx.sv
/*
 * uart byte receiver
 * synchronises the line, rechecks the start bit at half a bit,
 * samples data at mid-bit and drops bytes with a low stop bit
 */
`timescale 1ns/1ps
`default_nettype none

module uart_byte_rx import uart_frame_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       uart_rx,
	output logic [7:0] byte_data,
	output logic       byte_vld
);

	line_state_e state;
	logic [1:0]  sync_q;
	logic        rx_prev;
	logic        rx_s;
	logic        rx_fall;
	logic [15:0] clk_cnt;
	logic [3:0]  bit_cnt;

	assign rx_s    = sync_q[1];
	assign rx_fall = rx_prev && !rx_s;

	// two-flop synchroniser plus one stage for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sync_q  <= 2'b11;
			rx_prev <= 1'b1;
		end else begin
			sync_q  <= {sync_q[0], uart_rx};
			rx_prev <= rx_s;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= line_idle;
			clk_cnt   <= '0;
			bit_cnt   <= '0;
			byte_data <= '0;
			byte_vld  <= 1'b0;
		end else begin
			byte_vld <= 1'b0;
			case (state)
				line_idle: begin
					clk_cnt <= '0;
					if (rx_fall) begin
						state <= line_start;
					end
				end
				line_start: begin
					if (clk_cnt == clks_per_bit / 2 - 1) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						// a glitch that is gone by mid start bit
						state   <= rx_s ? line_idle : line_data;
					end else begin
						clk_cnt <= clk_cnt + 16'd1;
					end
				end
				line_data: begin
					if (clk_cnt == clks_per_bit - 1) begin
						clk_cnt   <= '0;
						byte_data <= {rx_s, byte_data[7:1]};
						if (bit_cnt == 4'd7) begin
							state <= line_stop;
						end else begin
							bit_cnt <= bit_cnt + 4'd1;
						end
					end else begin
						clk_cnt <= clk_cnt + 16'd1;
					end
				end
				line_stop: begin
					if (clk_cnt == clks_per_bit - 1) begin
						clk_cnt  <= '0;
						byte_vld <= rx_s;
						state    <= line_idle;
					end else begin
						clk_cnt <= clk_cnt + 16'd1;
					end
				end
				default: state <= line_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/frame_sender.sv
/*
 * frame sender
 * sends '&&', the content bytes and '&&' through the byte transmitter
 */
`timescale 1ns/1ps
`default_nettype none

module frame_sender import uart_frame_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  frame_t     tx_frame,
	input  logic       tx_req,
	input  logic       byte_done,
	output logic       tx_busy,
	output logic       tx_done,
	output logic [7:0] byte_data,
	output logic       byte_req
);

	tx_state_e state;
	frame_t    frame_q;
	logic [7:0] byte_cnt;
	logic [7:0] next_cnt;
	logic       last_byte;

	assign tx_busy   = (state != tx_idle);
	assign tx_done   = (state == tx_finish);
	assign next_cnt  = byte_cnt + 8'd1;
	// stop at the length, and never index past the buffer
	assign last_byte = (next_cnt >= frame_q.length) || (next_cnt >= max_bytes);

	// frame is captured only on an accepted request
	always_ff @(posedge sys_clk) begin
		if (state == tx_idle && tx_req) begin
			frame_q <= tx_frame;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= tx_idle;
			byte_cnt  <= '0;
			byte_data <= '0;
			byte_req  <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			case (state)
				tx_idle: begin
					if (tx_req) begin
						state     <= tx_mark1;
						byte_data <= frame_marker;
						byte_req  <= 1'b1;
					end
				end
				tx_mark1: begin
					if (byte_done) begin
						state     <= tx_mark2;
						byte_data <= frame_marker;
						byte_req  <= 1'b1;
					end
				end
				tx_mark2: begin
					if (byte_done) begin
						state     <= tx_content;
						byte_cnt  <= '0;
						byte_data <= frame_q.text[7:0];
						byte_req  <= 1'b1;
					end
				end
				tx_content: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (last_byte) begin
							state     <= tx_mark3;
							byte_data <= frame_marker;
						end else begin
							byte_cnt  <= next_cnt;
							byte_data <= frame_q.text[next_cnt*8 +: 8];
						end
					end
				end
				tx_mark3: begin
					if (byte_done) begin
						state     <= tx_mark4;
						byte_data <= frame_marker;
						byte_req  <= 1'b1;
					end
				end
				tx_mark4: begin
					if (byte_done) begin
						state <= tx_finish;
					end
				end
				tx_finish: state <= tx_idle;
				default:   state <= tx_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/frame_receiver.sv
/*
 * frame receiver
 * hunts for '&&', collects content up to the closing '&&'
 * and presents the finished string with its length
 */
`timescale 1ns/1ps
`default_nettype none

module frame_receiver import uart_frame_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_vld,
	output frame_t     rx_frame,
	output logic       rx_busy,
	output logic       rx_done
);

	rx_state_e state;
	logic [max_bytes*8-1:0] work_text;
	logic [7:0] byte_cnt;
	logic       is_marker;
	logic       wr_en;
	logic       commit;

	assign is_marker = (byte_data == frame_marker);
	assign rx_busy   = (state != rx_hunt);
	// content byte with room left in the buffer
	assign wr_en     = (state == rx_content) && byte_vld && !is_marker
		&& (byte_cnt < max_bytes);
	// closing second '&' of a non-empty frame
	assign commit    = (state == rx_close) && byte_vld && is_marker && (byte_cnt != 8'd0);

	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			work_text[byte_cnt*8 +: 8] <= byte_data;
		end
		if (commit) begin
			rx_frame.text   <= work_text;
			rx_frame.length <= byte_cnt;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= rx_hunt;
			byte_cnt <= '0;
			rx_done  <= 1'b0;
		end else begin
			rx_done <= commit;
			if (byte_vld) begin
				case (state)
					rx_hunt: begin
						if (is_marker) begin
							state <= rx_mark1;
						end
					end
					rx_mark1: begin
						byte_cnt <= '0;
						state    <= is_marker ? rx_content : rx_hunt;
					end
					rx_content: begin
						if (is_marker) begin
							state <= rx_close;
						end else if (byte_cnt >= max_bytes) begin
							// overlong content
							state <= rx_hunt;
						end else begin
							byte_cnt <= byte_cnt + 8'd1;
						end
					end
					rx_close: state <= rx_hunt;
					default:  state <= rx_hunt;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_frame_top.sv
/*
 * uart text-frame link top level
 * frame sender and receiver joined to the byte transmitter and receiver
 */
`timescale 1ns/1ps
`default_nettype none

module uart_frame_top import uart_frame_pkg::*; (
	input  logic   sys_clk,
	input  logic   sys_rst_n,
	input  frame_t tx_frame,
	input  logic   tx_req,
	input  logic   uart_rx,
	output logic   tx_busy,
	output logic   tx_done,
	output frame_t rx_frame,
	output logic   rx_busy,
	output logic   rx_done,
	output logic   uart_tx
);

	logic [7:0] tx_byte_data;
	logic       tx_byte_req;
	logic       tx_byte_done;
	logic [7:0] rx_byte_data;
	logic       rx_byte_vld;

	frame_sender u_frame_sender (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_frame  (tx_frame),
		.tx_req    (tx_req),
		.byte_done (tx_byte_done),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (tx_byte_data),
		.byte_req  (tx_byte_req)
	);

	uart_byte_tx u_byte_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (tx_byte_data),
		.byte_req  (tx_byte_req),
		.byte_done (tx_byte_done),
		.uart_tx   (uart_tx)
	);

	uart_byte_rx u_byte_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.uart_rx   (uart_rx),
		.byte_data (rx_byte_data),
		.byte_vld  (rx_byte_vld)
	);

	frame_receiver u_frame_receiver (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (rx_byte_data),
		.byte_vld  (rx_byte_vld),
		.rx_frame  (rx_frame),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done)
	);

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
/*
 * testbench clock and reset
 * 20 ns sys_clk, sys_rst_n held low for the first 16 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic sys_clk,
	output logic sys_rst_n
);

	localparam int half_period  = 10;
	localparam int reset_cycles = 16;

	initial begin
		sys_clk = 1'b0;
		forever #(half_period) sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst_n = 1'b0;
		repeat (reset_cycles) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: tb/tb_uart_frame.sv
/*
 * testbench for the uart text-frame link
 * loopback and driven serial stimulus, a line monitor on uart_tx
 * and a scoreboard of expected bytes and frames
 */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_frame import uart_frame_pkg::*; ();

	localparam int reset_cycles   = 16;
	// 20 loopback, 1 busy, 4 malformed, 1 valid, 1 stop-bit error
	localparam int n_frames       = 27;
	localparam int timeout_cycles =
		2 * n_frames * (max_bytes + 4) * 11 * clks_per_bit + reset_cycles;

	logic   sys_clk;
	logic   sys_rst_n;
	frame_t tx_frame;
	logic   tx_req;
	logic   uart_rx;
	logic   tx_busy;
	logic   tx_done;
	frame_t rx_frame;
	logic   rx_busy;
	logic   rx_done;
	logic   uart_tx;

	logic   use_drv;
	logic   drv_line;
	int     seed = 32'h87d0;
	int     value_errs = 0;
	int     other_errs = 0;
	int     pending_done = 0;
	int     rx_in_period = 0;
	int     rst_seen = 0;
	logic   have_rx = 1'b0;
	logic   busy_q = 1'b0;
	logic   done_q = 1'b0;
	logic   rx_busy_q = 1'b0;
	frame_t last_rx;

	logic [7:0] tx_exp_q[$];
	frame_t     rx_exp_q[$];

	tb_clock_gen u_clock_gen (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n)
	);

	// loopback unless the serial driver is selected
	assign uart_rx = use_drv ? drv_line : uart_tx;

	uart_frame_top u_dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_frame  (tx_frame),
		.tx_req    (tx_req),
		.uart_rx   (uart_rx),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_frame  (rx_frame),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.uart_tx   (uart_tx)
	);

	task automatic report_mismatch(input string msg);
		value_errs++;
		$display("Fail %0t ns: %s", $time, msg);
	endtask

	task automatic report_problem(input string msg);
		other_errs++;
		$display("%s", msg);
	endtask

	task automatic print_counts();
		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
	endtask

	task automatic check_rx_idle(input string what);
		assert (rx_busy === 1'b0)
		else report_mismatch($sformatf("rx_busy high after %s", what));
	endtask

	task automatic make_frame(output frame_t f, input int len);
		logic [7:0] b;
		f = '0;
		f.length = len[7:0];
		for (int k = 0; k < len; k++) begin
			b = frame_marker;
			while (b == frame_marker) begin
				b = $random(seed);
			end
			f.text[k*8 +: 8] = b;
		end
	endtask

	// request a frame in loopback and record what must come back
	task automatic send_frame(input frame_t f);
		@(posedge sys_clk);
		while (tx_busy !== 1'b0) @(posedge sys_clk);
		tx_frame <= f;
		tx_req   <= 1'b1;
		tx_exp_q.push_back(frame_marker);
		tx_exp_q.push_back(frame_marker);
		for (int k = 0; k < f.length; k++) begin
			tx_exp_q.push_back(f.text[k*8 +: 8]);
		end
		tx_exp_q.push_back(frame_marker);
		tx_exp_q.push_back(frame_marker);
		rx_exp_q.push_back(f);
		pending_done++;
		@(posedge sys_clk);
		tx_req <= 1'b0;
	endtask

	task automatic wait_tx_done();
		@(posedge sys_clk);
		while (tx_done !== 1'b1) @(posedge sys_clk);
	endtask

	task automatic drive_bit(input logic v);
		drv_line <= v;
		repeat (clks_per_bit) @(posedge sys_clk);
	endtask

	task automatic drive_byte(input logic [7:0] b, input logic stop_ok);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			drive_bit(b[i]);
		end
		drive_bit(stop_ok);
		// idle bit so the next start edge is visible
		if (!stop_ok) begin
			drive_bit(1'b1);
		end
	endtask

	// byte bad_idx goes out with a low stop bit and is left out of the prediction
	task automatic drive_frame(input frame_t f, input int bad_idx);
		frame_t want;
		int     n;
		want = '0;
		n = 0;
		for (int k = 0; k < f.length; k++) begin
			if (k != bad_idx) begin
				want.text[n*8 +: 8] = f.text[k*8 +: 8];
				n++;
			end
		end
		want.length = n[7:0];
		rx_exp_q.push_back(want);
		drive_byte(frame_marker, 1'b1);
		drive_byte(frame_marker, 1'b1);
		for (int k = 0; k < f.length; k++) begin
			drive_byte(f.text[k*8 +: 8], k != bad_idx);
		end
		drive_byte(frame_marker, 1'b1);
		drive_byte(frame_marker, 1'b1);
	endtask

	always @(posedge sys_clk) begin : reset_check
		if (rst_seen >= 1 && rst_seen < 20) begin
			assert (tx_busy === 1'b0 && tx_done === 1'b0 && rx_busy === 1'b0
				&& rx_done === 1'b0 && uart_tx === 1'b1)
			else report_mismatch("outputs not idle around reset");
		end
		if (rst_seen < 20) begin
			rst_seen++;
		end
	end

	// independent decode of uart_tx with two stop bits per byte
	initial begin : line_monitor
		logic [7:0] b;
		logic [7:0] want;
		forever begin
			@(posedge sys_clk);
			if (sys_rst_n === 1'b1 && uart_tx === 1'b0) begin
				repeat (clks_per_bit / 2 - 1) @(posedge sys_clk);
				assert (uart_tx === 1'b0) else report_mismatch("start bit not low at mid-bit");
				for (int i = 0; i < 8; i++) begin
					repeat (clks_per_bit) @(posedge sys_clk);
					b[i] = uart_tx;
				end
				for (int s = 0; s < tx_stop_bits; s++) begin
					repeat (clks_per_bit) @(posedge sys_clk);
					assert (uart_tx === 1'b1)
					else report_mismatch($sformatf("stop bit %0d low after byte %h", s, b));
				end
				if (tx_exp_q.size() == 0) begin
					report_problem($sformatf("byte %h sent on uart_tx with none expected", b));
				end else begin
					want = tx_exp_q.pop_front();
					assert (b === want)
					else report_mismatch($sformatf("uart_tx byte %h, expected %h", b, want));
				end
			end
		end
	end

	always @(posedge sys_clk) begin : scoreboard
		frame_t want;
		if (sys_rst_n === 1'b1) begin
			if (uart_tx === 1'b0) begin
				assert (tx_busy === 1'b1) else report_mismatch("uart_tx active with tx_busy low");
			end
			// busy may only drop in the cycle after tx_done
			if (busy_q === 1'b1 && tx_busy === 1'b0) begin
				assert (done_q === 1'b1) else report_mismatch("tx_busy fell before tx_done");
			end
			if (tx_done === 1'b1) begin
				assert (pending_done > 0) else report_mismatch("tx_done without a request");
				assert (tx_exp_q.size() == 0)
				else report_mismatch("tx_done before the whole frame was on the line");
				if (!use_drv) begin
					assert (rx_in_period == 1)
					else report_mismatch($sformatf("%0d rx_done in frame period", rx_in_period));
				end
				pending_done--;
				rx_in_period = 0;
			end
			if (rx_done === 1'b1) begin
				rx_in_period++;
				assert (rx_busy_q === 1'b1)
				else report_mismatch("rx_done without rx_busy in the cycle before");
				if (rx_exp_q.size() == 0) begin
					report_problem("rx_done pulsed although no frame was expected");
				end else begin
					want = rx_exp_q.pop_front();
					assert (rx_frame.length === want.length)
					else report_mismatch($sformatf("rx length %0d, expected %0d",
						rx_frame.length, want.length));
					for (int k = 0; k < want.length; k++) begin
						assert (rx_frame.text[k*8 +: 8] === want.text[k*8 +: 8])
						else report_mismatch($sformatf("rx byte %0d is %h, expected %h", k,
							rx_frame.text[k*8 +: 8], want.text[k*8 +: 8]));
					end
				end
				last_rx = rx_frame;
				have_rx = 1'b1;
			end else if (have_rx) begin
				assert (rx_frame === last_rx) else report_mismatch("rx_frame changed without rx_done");
			end
			busy_q    = tx_busy;
			done_q    = tx_done;
			rx_busy_q = rx_busy;
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge sys_clk);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", cycles);
		print_counts();
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : stimulus
		frame_t f;
		frame_t g;
		tx_frame = '0;
		tx_req   = 1'b0;
		use_drv  = 1'b0;
		drv_line = 1'b1;
		@(posedge sys_rst_n);
		repeat (4) @(posedge sys_clk);

		// loopback round trips
		for (int n = 0; n < 20; n++) begin
			make_frame(f, 1 + ($unsigned($random(seed)) % max_bytes));
			send_frame(f);
			wait_tx_done();
		end

		// second request while busy must be ignored
		make_frame(f, 12);
		send_frame(f);
		while (tx_busy !== 1'b1) @(posedge sys_clk);
		make_frame(g, 5);
		tx_frame <= g;
		tx_req   <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		wait_tx_done();

		// serial driver from here on
		repeat (clks_per_bit) @(posedge sys_clk);
		use_drv <= 1'b1;
		repeat (clks_per_bit) @(posedge sys_clk);

		// lone marker then content
		drive_byte(frame_marker, 1'b1);
		drive_byte(8'h41, 1'b1);
		drive_byte(8'h42, 1'b1);
		check_rx_idle("a lone marker");
		// '&' inside content followed by a non-marker
		drive_byte(frame_marker, 1'b1);
		drive_byte(frame_marker, 1'b1);
		drive_byte(8'h43, 1'b1);
		drive_byte(frame_marker, 1'b1);
		drive_byte(8'h44, 1'b1);
		check_rx_idle("a broken closing pair");
		// empty frame
		repeat (4) drive_byte(frame_marker, 1'b1);
		check_rx_idle("an empty frame");
		// 33 content bytes
		drive_byte(frame_marker, 1'b1);
		drive_byte(frame_marker, 1'b1);
		for (int k = 0; k < max_bytes + 1; k++) begin
			drive_byte(8'h41 + k[7:0], 1'b1);
		end
		check_rx_idle("overlong content");
		drive_byte(frame_marker, 1'b1);
		drive_byte(frame_marker, 1'b1);
		// the closing pair reopens a frame and '&' plus a filler returns to hunt
		drive_byte(frame_marker, 1'b1);
		drive_byte(8'h5a, 1'b1);

		make_frame(f, 1 + ($unsigned($random(seed)) % max_bytes));
		drive_frame(f, -1);
		repeat (2 * clks_per_bit) @(posedge sys_clk);

		// low stop bit on content byte 3
		make_frame(f, 8);
		drive_frame(f, 3);

		repeat (4 * clks_per_bit) @(posedge sys_clk);
		while (tx_busy !== 1'b0 || rx_busy !== 1'b0) @(posedge sys_clk);
		assert (tx_exp_q.size() == 0)
		else report_problem("bytes expected on uart_tx were never sent");
		assert (rx_exp_q.size() == 0)
		else report_problem("expected frames were never received");
		assert (pending_done == 0)
		else report_problem("accepted requests ended without tx_done");

		print_counts();
		if (value_errs + other_errs == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
verilog/uart_frame_pkg.sv
verilog/uart_byte_tx.sv
verilog/uart_byte_rx.sv
verilog/frame_sender.sv
verilog/frame_receiver.sv
verilog/uart_frame_top.sv
tb/tb_clock_gen.sv
tb/tb_uart_frame.sv
